//--- source/interp_pkg.sv
/*
 * Shared types and constants for the FM output interpolator.
 * Sample, coefficient and accumulator widths, the fixed 8-tap low-pass
 * filter and the zero-stuffing phase order. Imported by every RTL block.
 */
`default_nettype none

package interp_pkg;

	// Audio path
	typedef logic signed [11:0] audio_t;        // Signed 12-bit sample
	localparam audio_t AUDIO_MAX = 12'sd2047;   // Clamp ceiling
	localparam audio_t AUDIO_MIN = -12'sd2048;  // Clamp floor

	// Filter arithmetic
	typedef logic signed [9:0]  coef_t;         // Signed 10-bit tap weight
	typedef logic signed [25:0] acc_t;          // 8 x (12x10) products, with headroom

	localparam int NUM_TAPS = 8;                // Filter length
	typedef logic [$clog2(NUM_TAPS)-1:0] tap_idx_t;  // Tap number, also history age

	// Symmetric low-pass taps, index is sample age (0 = newest)
	// Sum is 1024, so DC gain is 2 after the shift below,
	// which restores level lost to the two zero phases
	localparam coef_t COEFS [NUM_TAPS] = '{
		10'sd16,
		10'sd64,
		10'sd160,
		10'sd272,
		10'sd272,
		10'sd160,
		10'sd64,
		10'sd16
	};

	localparam int COEF_SHIFT = 9;              // Arithmetic shift before clamping

	// Zero-stuffing order, one phase per history write
	typedef enum logic [1:0] {
		PH_FM,      // FM stereo pair
		PH_ZERO_A,  // Inserted zero
		PH_OTHER,   // Second source pair, e.g. filtered PSG
		PH_ZERO_B   // Inserted zero
	} phase_t;

endpackage

`default_nettype wire

//--- source/history_if.sv
/*
 * Link between the zero-stuffing sequencer, the history buffer and the MAC.
 * The sequencer pushes one stereo word per phase, the MAC reads back by age.
 */
`timescale 1ns/100ps
`default_nettype none

interface history_if;
	import interp_pkg::*;

	logic     wr_en;     // One-cycle write strobe, also the MAC start
	audio_t   wr_left;   // Word to store
	audio_t   wr_right;
	tap_idx_t rd_age;    // 0 = newest word
	audio_t   rd_left;   // Combinational read data
	audio_t   rd_right;

	modport writer (
		output wr_en, wr_left, wr_right
	);

	modport store (
		input  wr_en, wr_left, wr_right, rd_age,
		output rd_left, rd_right
	);

	modport reader (
		input  wr_en, rd_left, rd_right,
		output rd_age
	);

endinterface

`default_nettype wire

//--- source/zero_stuff_sequencer.sv
/*
 * Phase sequencer for 4x zero-stuffing. Every CYCLES_PER_PHASE clocks it
 * writes one stereo word to the history: FM pair, zero, other pair, zero.
 */
`timescale 1ns/100ps
`default_nettype none

module zero_stuff_sequencer #(
	parameter int CYCLES_PER_PHASE = 42
) (
	input  logic              clk,
	input  logic              rst,
	input  interp_pkg::audio_t fm_left,
	input  interp_pkg::audio_t fm_right,
	input  interp_pkg::audio_t other_left,
	input  interp_pkg::audio_t other_right,
	history_if.writer         hist
);
	import interp_pkg::*;

	localparam int CNT_W = (CYCLES_PER_PHASE > 1) ? $clog2(CYCLES_PER_PHASE) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CYCLES_PER_PHASE - 1);

	logic [CNT_W-1:0] cnt;    // Clocks within the current phase
	phase_t           phase;  // Source for the next write
	logic             wrap;

	assign wrap = (cnt == CNT_LAST);  // Last clock of the phase

	// Counter, phase and strobe
	always_ff @(posedge clk) begin
		if (rst) begin
			cnt        <= '0;
			phase      <= PH_FM;
			hist.wr_en <= 1'b0;
		end else begin
			hist.wr_en <= wrap;  // Strobe lands in the cycle after the wrap
			if (wrap) begin
				cnt   <= '0;
				phase <= phase_t'(phase + 2'd1);  // Wraps back to PH_FM after PH_ZERO_B
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	// Stereo word, pair captured together on the wrap clock
	always_ff @(posedge clk) begin
		if (wrap) begin
			case (phase)
				PH_FM: begin
					hist.wr_left  <= fm_left;
					hist.wr_right <= fm_right;
				end
				PH_OTHER: begin
					hist.wr_left  <= other_left;
					hist.wr_right <= other_right;
				end
				PH_ZERO_A, PH_ZERO_B: begin
					hist.wr_left  <= '0;  // Stuffed zero
					hist.wr_right <= '0;
				end
				default: begin
					hist.wr_left  <= '0;
					hist.wr_right <= '0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/history_buffer.sv
/*
 * Circular store of the last NUM_TAPS stereo words.
 * Written on the sequencer strobe, read combinationally by age so the
 * MAC only ever asks for "n writes ago".
 */
`timescale 1ns/100ps
`default_nettype none

module history_buffer (
	input  logic     clk,
	input  logic     rst,
	history_if.store hist
);
	import interp_pkg::*;

	audio_t   left_mem  [NUM_TAPS];  // Left history
	audio_t   right_mem [NUM_TAPS];  // Right history
	tap_idx_t wr_ptr;                // Next slot to fill
	tap_idx_t newest;                // Slot of the last write
	tap_idx_t rd_ptr;                // Slot for the requested age

	// Age to slot, modulo NUM_TAPS through the index width
	assign newest = wr_ptr - 1'b1;
	assign rd_ptr = newest - hist.rd_age;

	assign hist.rd_left  = left_mem[rd_ptr];
	assign hist.rd_right = right_mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			for (int i = 0; i < NUM_TAPS; i++) begin
				left_mem[i]  <= '0;  // Silent history after reset
				right_mem[i] <= '0;
			end
		end else if (hist.wr_en) begin
			left_mem[wr_ptr]  <= hist.wr_left;
			right_mem[wr_ptr] <= hist.wr_right;
			wr_ptr            <= wr_ptr + 1'b1;  // Oldest word gets overwritten next
		end
	end

endmodule

`default_nettype wire

//--- source/fir_mac.sv
/*
 * Tap-serial FIR for both channels. Starts on each history write, walks
 * ages 0..NUM_TAPS-1 one per clock, then shifts, clamps and registers the
 * stereo result with a one-cycle sample_out pulse.
 */
`timescale 1ns/100ps
`default_nettype none

module fir_mac #(
	parameter int CYCLES_PER_PHASE = 42
) (
	input  logic               clk,
	input  logic               rst,
	history_if.reader          hist,
	output interp_pkg::audio_t left_out,
	output interp_pkg::audio_t right_out,
	output logic               sample_out
);
	import interp_pkg::*;

	// MAC must be idle again before the next strobe
	if (CYCLES_PER_PHASE < NUM_TAPS + 4) begin : g_phase_check
		$error("CYCLES_PER_PHASE too short for %0d taps", NUM_TAPS);
	end

	tap_idx_t tap;         // Current age being summed
	logic     busy;        // Walking the taps
	logic     done;        // Sums complete, output next clock
	acc_t     acc_left;
	acc_t     acc_right;
	acc_t     prod_left;
	acc_t     prod_right;
	acc_t     shr_left;
	acc_t     shr_right;

	// Clamp a shifted sum into the audio range
	function automatic audio_t saturate(input acc_t v);
		if (v > acc_t'(AUDIO_MAX))
			return AUDIO_MAX;
		else if (v < acc_t'(AUDIO_MIN))
			return AUDIO_MIN;
		else
			return audio_t'(v);
	endfunction

	assign hist.rd_age = tap;

	// Signed products, sign extended to accumulator width
	assign prod_left  = hist.rd_left * COEFS[tap];
	assign prod_right = hist.rd_right * COEFS[tap];

	assign shr_left  = acc_left >>> COEF_SHIFT;
	assign shr_right = acc_right >>> COEF_SHIFT;

	// Tap sequencing
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			done <= 1'b0;
			tap  <= '0;
		end else begin
			done <= 1'b0;
			if (hist.wr_en) begin
				busy <= 1'b1;  // Fresh word is age 0 from next cycle
				tap  <= '0;
			end else if (busy) begin
				tap <= tap + 1'b1;
				if (tap == tap_idx_t'(NUM_TAPS - 1)) begin
					busy <= 1'b0;
					done <= 1'b1;  // Last product added this edge
				end
			end
		end
	end

	// Accumulators
	always_ff @(posedge clk) begin
		if (hist.wr_en) begin
			acc_left  <= '0;
			acc_right <= '0;
		end else if (busy) begin
			acc_left  <= acc_left + prod_left;
			acc_right <= acc_right + prod_right;
		end
	end

	// Output registers, held between pulses
	always_ff @(posedge clk) begin
		if (rst) begin
			left_out   <= '0;
			right_out  <= '0;
			sample_out <= 1'b0;
		end else begin
			sample_out <= done;
			if (done) begin
				left_out  <= saturate(shr_left);
				right_out <= saturate(shr_right);
			end
		end
	end

endmodule

`default_nettype wire

//--- source/interpolator_top.sv
/*
 * FM output interpolator, raises the sample rate by four.
 * FM and a second same-rate source are interleaved with zeros and
 * low-pass filtered. One sample_out pulse per phase.
 */
`timescale 1ns/100ps
`default_nettype none

module interpolator_top #(
	parameter int CYCLES_PER_PHASE = 42  // Clocks per output sample
) (
	input  logic               clk,
	input  logic               rst,
	input  interp_pkg::audio_t fm_left,
	input  interp_pkg::audio_t fm_right,
	input  interp_pkg::audio_t other_left,   // Must already be at the FM rate
	input  interp_pkg::audio_t other_right,
	output interp_pkg::audio_t left_out,
	output interp_pkg::audio_t right_out,
	output logic               sample_out
);

	history_if hist ();  // Sequencer -> buffer -> MAC

	// Producer, stuffs zeros between the two sources
	zero_stuff_sequencer #(
		.CYCLES_PER_PHASE(CYCLES_PER_PHASE)
	) u_seq (
		.clk        (clk),
		.rst        (rst),
		.fm_left    (fm_left),
		.fm_right   (fm_right),
		.other_left (other_left),
		.other_right(other_right),
		.hist       (hist.writer)
	);

	// Last NUM_TAPS words
	history_buffer u_buf (
		.clk (clk),
		.rst (rst),
		.hist(hist.store)
	);

	// Consumer, one filtered stereo sample per write
	fir_mac #(
		.CYCLES_PER_PHASE(CYCLES_PER_PHASE)
	) u_mac (
		.clk       (clk),
		.rst       (rst),
		.hist      (hist.reader),
		.left_out  (left_out),
		.right_out (right_out),
		.sample_out(sample_out)
	);

endmodule

`default_nettype wire

//--- testbench/interpolator_properties.sv
/*
 * Output timing checks, bound into interpolator_top.
 * Quiet outputs until the first sample, first pulse position,
 * single-cycle pulses and a fixed spacing of CYCLES_PER_PHASE.
 */
`timescale 1ns/100ps
`default_nettype none

module interpolator_properties #(
	parameter int CYCLES_PER_PHASE = 42
) (
	input logic               clk,
	input logic               rst,
	input logic               sample_out,
	input interp_pkg::audio_t left_out,
	input interp_pkg::audio_t right_out
);
	import interp_pkg::*;

	localparam int FIRST_PULSE = CYCLES_PER_PHASE + NUM_TAPS + 2;  // Strobe plus MAC walk

	int   cyc;             // Cycle number, 0 at first edge out of reset
	logic seen_pulse;      // First sample_out has gone by
	int   fail_count = 0;  // Failed timing checks so far

	always_ff @(posedge clk) begin
		if (rst) begin
			cyc        <= 0;
			seen_pulse <= 1'b0;
		end else begin
			cyc <= cyc + 1;
			if (sample_out)
				seen_pulse <= 1'b1;
		end
	end

	a_quiet_outputs: assert property (@(posedge clk) disable iff (rst)
		!seen_pulse && !sample_out |-> left_out == '0 && right_out == '0)
		else begin
			fail_count++;
			$error("outputs not zero before the first sample");
		end

	a_no_early_pulse: assert property (@(posedge clk) disable iff (rst)
		cyc < FIRST_PULSE |-> !sample_out)
		else begin
			fail_count++;
			$error("sample_out high before cycle %0d", FIRST_PULSE);
		end

	a_first_pulse: assert property (@(posedge clk) disable iff (rst)
		cyc == FIRST_PULSE |-> sample_out)
		else begin
			fail_count++;
			$error("no sample_out in cycle %0d", FIRST_PULSE);
		end

	// One clock high, then low until the next phase
	a_pulse_spacing: assert property (@(posedge clk) disable iff (rst)
		sample_out |=> (!sample_out) [*(CYCLES_PER_PHASE - 1)] ##1 sample_out)
		else begin
			fail_count++;
			$error("sample_out not a pulse every %0d cycles", CYCLES_PER_PHASE);
		end

endmodule

bind interpolator_top interpolator_properties #(
	.CYCLES_PER_PHASE(CYCLES_PER_PHASE)
) props (
	.clk       (clk),
	.rst       (rst),
	.sample_out(sample_out),
	.left_out  (left_out),
	.right_out (right_out)
);

`default_nettype wire

//--- testbench/interpolator_tb.sv
/*
 * Testbench for the FM output interpolator. Drives impulse, interleave,
 * full-scale and random stereo input through interpolator_top and checks
 * every filtered sample against a behavioral FIR with assertions.
 */
`timescale 1ns/100ps
`default_nettype none

module interpolator_tb;
	import interp_pkg::*;

	localparam int CPP        = 16;                      // Clocks per phase in this run
	localparam int CLK_PERIOD = 8;                       // ns
	localparam int NUM_PULSES = 124;                     // Writes driven over all tests
	localparam int WATCHDOG_NS = (NUM_PULSES + 4) * CPP * CLK_PERIOD;

	logic   clk;
	logic   rst;
	audio_t fm_left, fm_right, other_left, other_right;  // DUT inputs
	audio_t left_out, right_out;
	logic   sample_out;

	int     seed;                 // $random state
	int     pulses;               // sample_out pulses seen so far
	int     hist_l [NUM_TAPS];    // Model history, index is age
	int     hist_r [NUM_TAPS];
	int     word_l, word_r;       // Word the DUT wrote this phase
	phase_t model_phase;
	audio_t exp_left, exp_right;  // Expected outputs after the latest pulse

	interpolator_top #(
		.CYCLES_PER_PHASE(CPP)
	) uut (
		.clk        (clk),
		.rst        (rst),
		.fm_left    (fm_left),
		.fm_right   (fm_right),
		.other_left (other_left),
		.other_right(other_right),
		.left_out   (left_out),
		.right_out  (right_out),
		.sample_out (sample_out)
	);

	// Direct-form FIR over the model history, floor shift then clamp
	function automatic audio_t fir_expected(input int h [NUM_TAPS]);
		int acc;
		acc = 0;
		for (int a = 0; a < NUM_TAPS; a++)
			acc += h[a] * COEFS[a];
		acc = acc >>> COEF_SHIFT;
		if (acc > 2047)
			return 12'sd2047;
		else if (acc < -2048)
			return -12'sd2048;
		return audio_t'(acc);
	endfunction

	// Inputs held during write k
	task automatic set_inputs(input int k);
		audio_t fl, fr, ol, orr;
		if (k < 12) begin              // Single FM impulse on the left, write 0 is PH_FM
			fl  = (k == 0) ? 12'sd256 : 12'sd0;
			fr  = '0;
			ol  = '0;
			orr = '0;
		end else if (k < 28) begin     // Two different constants, one per source
			fl  = 12'sd300;
			fr  = -12'sd200;
			ol  = -12'sd150;
			orr = 12'sd500;
		end else if (k < 44) begin     // Full scale positive
			fl  = 12'sd2047;
			fr  = 12'sd2047;
			ol  = 12'sd2047;
			orr = 12'sd2047;
		end else if (k < 60) begin     // Full scale negative
			fl  = -12'sd2048;
			fr  = -12'sd2048;
			ol  = -12'sd2048;
			orr = -12'sd2048;
		end else begin
			fl  = audio_t'($random(seed));
			fr  = audio_t'($random(seed));
			ol  = audio_t'($random(seed));
			orr = audio_t'($random(seed));
		end
		fm_left     <= fl;
		fm_right    <= fr;
		other_left  <= ol;
		other_right <= orr;
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Reference model, steps once per pulse and then moves the inputs on
	always @(posedge clk) begin
		if (sample_out) begin
			model_phase = phase_t'(pulses % 4);  // FM, zero, other, zero
			case (model_phase)
				PH_FM: begin
					word_l = fm_left;
					word_r = fm_right;
				end
				PH_OTHER: begin
					word_l = other_left;
					word_r = other_right;
				end
				default: begin
					word_l = 0;   // Stuffed zero
					word_r = 0;
				end
			endcase
			for (int a = NUM_TAPS - 1; a > 0; a--) begin
				hist_l[a] = hist_l[a-1];
				hist_r[a] = hist_r[a-1];
			end
			hist_l[0] = word_l;
			hist_r[0] = word_r;
			exp_left  = fir_expected(hist_l);
			exp_right = fir_expected(hist_r);
			pulses    = pulses + 1;
			set_inputs(pulses);  // Next phase samples these
		end
	end

	// Outputs hold after the pulse, so check them one clock later
	a_left_value: assert property (@(posedge clk) disable iff (rst)
		sample_out |=> left_out == exp_left)
		else begin
			$display("[FAIL] %0t left_out expected %0d got %0d",
				$time, exp_left, $sampled(left_out));
			$display("Errors found");
			$fatal(1, "left channel mismatch");
		end

	a_right_value: assert property (@(posedge clk) disable iff (rst)
		sample_out |=> right_out == exp_right)
		else begin
			$display("[FAIL] %0t right_out expected %0d got %0d",
				$time, exp_right, $sampled(right_out));
			$display("Errors found");
			$fatal(1, "right channel mismatch");
		end

	// Timing properties count their failures in the bound checker
	always @(posedge clk) begin
		if (uut.props.fail_count != 0) begin
			$display("Errors found");
			$fatal(1, "a timing property of the output pulse failed");
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Output pulses stopped, %0d of %0d seen", pulses, NUM_PULSES);
		$display("Errors found");
		$fatal(1, "watchdog expired");
	end

	initial begin
		seed   = 9909;
		pulses = 0;
		rst    = 1'b1;
		set_inputs(0);
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		wait (pulses == NUM_PULSES);
		repeat (2) @(posedge clk);   // Let the last value check fire
		if (uut.props.fail_count == 0) begin
			$display("No errors");
			$finish;
		end else begin
			$display("Errors found");
			$fatal(1, "a timing property of the output pulse failed");
		end
	end

endmodule

`default_nettype wire

//--- files.f
source/interp_pkg.sv
source/history_if.sv
source/zero_stuff_sequencer.sv
source/history_buffer.sv
source/fir_mac.sv
source/interpolator_top.sv
testbench/interpolator_properties.sv
testbench/interpolator_tb.sv
